/* Makefile */
# Verilator build and run of the register-file testbench

SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := regfileBench
FILELIST := build.f
OBJDIR   := obj_dir
PASSTEXT := SIMULATION PASSED

BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

/* bench/clockGen.sv */
// clk2x runs from time zero with a 40 ns period; rstN is released on a falling edge after 10 cycles
`timescale 1ns/1ps

module clockGen (
	output logic clk2x,
	output logic rstN
);

	// 20 ns half period gives the 40 ns clk2x
	initial begin
		clk2x = 1'b0;
		forever #20 clk2x = ~clk2x;
	end

	// release on a falling edge so the first rising edge already sees the design out of reset
	initial begin
		rstN = 1'b0;
		repeat (10) @(posedge clk2x);
		@(negedge clk2x);
		rstN = 1'b1;
	end

endmodule

/* bench/regfileBench.sv */
// directed tests of regfileTop; a cycle model checks every handshake and operand, run limited to 4000 cycles
`timescale 1ns/1ps

module regfileBench;
	import regPkg::*;

	// ============================================================
	// DUT connections
	// ============================================================

	logic clk2x;
	logic rstN;
	logic wbValid0;
	logic wbValid1;
	regAddr wbAddr0;
	regAddr wbAddr1;
	regWord wbData0;
	regWord wbData1;
	logic wbReady0;
	logic wbReady1;
	logic issueValid;
	regAddr issueSrcA;
	regAddr issueSrcB;
	logic issueReady;
	logic opValid;
	logic opReady;
	regWord opA;
	regWord opB;
	logic levelValid;
	levelSel level;
	logic levelReady;

	clockGen uClock (.clk2x(clk2x), .rstN(rstN));

	regfileTop dut (
		.clk2x(clk2x), .rstN(rstN),
		.wbValid0(wbValid0), .wbValid1(wbValid1),
		.wbAddr0(wbAddr0), .wbAddr1(wbAddr1),
		.wbData0(wbData0), .wbData1(wbData1),
		.wbReady0(wbReady0), .wbReady1(wbReady1),
		.issueValid(issueValid), .issueSrcA(issueSrcA), .issueSrcB(issueSrcB),
		.issueReady(issueReady),
		.opValid(opValid), .opReady(opReady), .opA(opA), .opB(opB),
		.levelValid(levelValid), .level(level), .levelReady(levelReady)
	);

	// ============================================================
	// reference model and bookkeeping
	// ============================================================

	// architectural state as the consumer should see it
	regWord mRegs [regCount];
	regWord mSp [levelCount];
	levelSel mLevel;
	// phase of the coming edge where high is the lane 0 slot
	logic mPhase;
	// one buffered result per lane, written in its slot
	logic [1:0] mPend;
	regAddr mAddr [2];
	regWord mData [2];
	// operand pair held toward the consumer
	logic mOpValid;
	regWord mOpA;
	regWord mOpB;

	// what transferred on the last edge
	logic [1:0] lastWbFire;
	logic lastIssueFire;
	logic lastLevelFire;

	string testName = "none";
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int seed = 49283;

	function automatic regWord randWord();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// the lane 1 buffer is looked at before lane 0 and the stored value comes last
	function automatic regWord predictRead(input regAddr src);
		if (src == '0)
			return '0;
		if (mPend[1] && mAddr[1] == src)
			return mData[1];
		if (mPend[0] && mAddr[0] == src)
			return mData[0];
		if (src == regAddr'(spIndex))
			return mSp[mLevel];
		return mRegs[src];
	endfunction

	// register 0 drops its writes and register 31 goes to the bank of the level
	function automatic void retireWrite(input regAddr addr, input regWord data);
		if (addr == regAddr'(spIndex))
			mSp[mLevel] = data;
		else if (addr != '0)
			mRegs[addr] = data;
	endfunction

	task automatic checkWord(input string what, input regWord expected, input regWord actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %s %s: expected %b, actual %b", testName, what, expected, actual);
		end
	endtask

	// ============================================================
	// one clk2x cycle in lockstep with the model
	// ============================================================

	// starts on a falling edge with the inputs driven and ends on the next one
	task automatic tick;
		logic commit0;
		logic commit1;
		logic [1:0] readyWb;
		logic [1:0] fireWb;
		logic readyIssue;
		logic readyLevel;
		logic fireIssue;
		logic fireLevel;
		regWord nextA;
		regWord nextB;
		#1;
		commit0 = mPhase && mPend[0];
		commit1 = !mPhase && mPend[1];
		readyWb = {!mPend[1] || commit1, !mPend[0] || commit0};
		readyIssue = !mOpValid || opReady;
		readyLevel = !mPend[0] && !mPend[1];
		checkBit("wbReady0", readyWb[0], wbReady0);
		checkBit("wbReady1", readyWb[1], wbReady1);
		checkBit("issueReady", readyIssue, issueReady);
		checkBit("levelReady", readyLevel, levelReady);
		fireWb = {wbValid1 && readyWb[1], wbValid0 && readyWb[0]};
		fireIssue = issueValid && readyIssue;
		fireLevel = levelValid && readyLevel;
		// operands are read before this edge's commits and bypass covers them
		nextA = predictRead(issueSrcA);
		nextB = predictRead(issueSrcB);
		@(posedge clk2x);
		if (commit0)
			retireWrite(mAddr[0], mData[0]);
		if (commit1)
			retireWrite(mAddr[1], mData[1]);
		if (fireWb[0]) begin
			mPend[0] = 1'b1;
			mAddr[0] = wbAddr0;
			mData[0] = wbData0;
		end else if (commit0) begin
			mPend[0] = 1'b0;
		end
		if (fireWb[1]) begin
			mPend[1] = 1'b1;
			mAddr[1] = wbAddr1;
			mData[1] = wbData1;
		end else if (commit1) begin
			mPend[1] = 1'b0;
		end
		if (fireIssue) begin
			mOpValid = 1'b1;
			mOpA = nextA;
			mOpB = nextB;
		end else if (opReady) begin
			mOpValid = 1'b0;
		end
		if (fireLevel)
			mLevel = level;
		mPhase = !mPhase;
		lastWbFire = fireWb;
		lastIssueFire = fireIssue;
		lastLevelFire = fireLevel;
		@(negedge clk2x);
		checkBit("opValid", mOpValid, opValid);
		if (mOpValid) begin
			checkWord("opA", mOpA, opA);
			checkWord("opB", mOpB, opB);
		end
	endtask

	// ============================================================
	// channel helpers
	// ============================================================

	task automatic writeLane(input logic lane, input regAddr addr, input regWord data);
		if (lane) begin
			wbValid1 = 1'b1;
			wbAddr1 = addr;
			wbData1 = data;
		end else begin
			wbValid0 = 1'b1;
			wbAddr0 = addr;
			wbData0 = data;
		end
		tick;
		while (!lastWbFire[lane])
			tick;
		if (lane)
			wbValid1 = 1'b0;
		else
			wbValid0 = 1'b0;
	endtask

	task automatic issueRead(input regAddr srcA, input regAddr srcB,
			output regWord gotA, output regWord gotB);
		issueValid = 1'b1;
		issueSrcA = srcA;
		issueSrcB = srcB;
		tick;
		while (!lastIssueFire)
			tick;
		issueValid = 1'b0;
		// exactly one cycle of latency, so the pair is already out
		checkBit("opValid after issue", 1'b1, opValid);
		gotA = opA;
		gotB = opB;
	endtask

	task automatic setLevel(input levelSel newLevel);
		levelValid = 1'b1;
		level = newLevel;
		tick;
		while (!lastLevelFire)
			tick;
		levelValid = 1'b0;
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic resetState;
		regWord gotA;
		regWord gotB;
		testName = "resetState";
		checkBit("opValid", 1'b0, opValid);
		checkBit("wbReady0", 1'b1, wbReady0);
		checkBit("wbReady1", 1'b1, wbReady1);
		checkBit("issueReady", 1'b1, issueReady);
		checkBit("levelReady", 1'b1, levelReady);
		issueRead('0, '0, gotA, gotB);
		checkWord("zero A", '0, gotA);
		checkWord("zero B", '0, gotB);
	endtask

	task automatic laneWriteRead;
		regWord value;
		regWord gotA;
		regWord gotB;
		testName = "laneWriteRead";
		for (int lane = 0; lane < 2; lane++) begin
			value = randWord();
			writeLane(lane[0], regAddr'(5 + lane), value);
			repeat (4) tick;
			issueRead(regAddr'(5 + lane), '0, gotA, gotB);
			checkWord("stored", value, gotA);
			checkWord("zero", '0, gotB);
			// the issue right after acceptance sees the entry still in its buffer
			value = randWord();
			writeLane(lane[0], regAddr'(5 + lane), value);
			issueRead(regAddr'(5 + lane), regAddr'(5 + lane), gotA, gotB);
			checkWord("bypass A", value, gotA);
			checkWord("bypass B", value, gotB);
		end
	endtask

	task automatic sameRegister;
		regWord value0;
		regWord value1;
		regWord gotA;
		regWord gotB;
		testName = "sameRegister";
		value0 = randWord();
		value1 = randWord();
		// accept on a low-phase edge so that the next base cycle writes lane 0 before lane 1
		while (mPend != 2'b00 || mPhase)
			tick;
		wbValid0 = 1'b1;
		wbAddr0 = regAddr'(9);
		wbData0 = value0;
		wbValid1 = 1'b1;
		wbAddr1 = regAddr'(9);
		wbData1 = value1;
		checkBit("lane 0 ready", 1'b1, wbReady0);
		checkBit("lane 1 ready", 1'b1, wbReady1);
		tick;
		wbValid0 = 1'b0;
		wbValid1 = 1'b0;
		repeat (4) tick;
		issueRead(regAddr'(9), regAddr'(9), gotA, gotB);
		checkWord("lane 1 wins", value1, gotA);
	endtask

	task automatic stackPointer;
		regWord spValue [levelCount];
		regWord gotA;
		regWord gotB;
		testName = "stackPointer";
		for (int l = 0; l < levelCount; l++) begin
			// the previous stack pointer write is still buffered here
			if (l > 0)
				checkBit("levelReady while pending", 1'b0, levelReady);
			setLevel(levelSel'(l));
			spValue[l] = randWord();
			writeLane(l[0], regAddr'(spIndex), spValue[l]);
		end
		for (int l = 0; l < levelCount; l++) begin
			setLevel(levelSel'(l));
			issueRead(regAddr'(spIndex), '0, gotA, gotB);
			checkWord("banked sp", spValue[l], gotA);
		end
	endtask

	task automatic backPressure;
		regWord expA;
		regWord expB;
		regWord gotA;
		regWord gotB;
		testName = "backPressure";
		// the pair from the last read leaves first so the stage starts empty
		tick;
		expA = predictRead(regAddr'(5));
		expB = predictRead(regAddr'(6));
		opReady = 1'b0;
		issueRead(regAddr'(5), regAddr'(6), gotA, gotB);
		checkWord("first A", expA, gotA);
		checkWord("first B", expB, gotB);
		// a second issue with swapped sources waits behind the stalled pair
		issueValid = 1'b1;
		issueSrcA = regAddr'(6);
		issueSrcB = regAddr'(5);
		repeat (3) begin
			tick;
			checkBit("issue stalled", 1'b0, issueReady);
			checkWord("opA held", expA, opA);
			checkWord("opB held", expB, opB);
		end
		opReady = 1'b1;
		checkWord("opA on release", expA, opA);
		checkWord("opB on release", expB, opB);
		tick;
		issueValid = 1'b0;
		checkWord("swapped A", expB, opA);
		checkWord("swapped B", expA, opB);
		tick;
	endtask

	task automatic randomTraffic;
		int writes;
		testName = "randomTraffic";
		// give every register a known value before random reads
		for (int i = 1; i < regCount; i++)
			writeLane(i[0], regAddr'(i), randWord());
		writes = 0;
		while (writes < 200) begin
			if (!wbValid0 && ($random(seed) & 1) != 0) begin
				wbValid0 = 1'b1;
				wbAddr0 = regAddr'($random(seed));
				wbData0 = randWord();
			end
			if (!wbValid1 && ($random(seed) & 1) != 0) begin
				wbValid1 = 1'b1;
				wbAddr1 = regAddr'($random(seed));
				wbData1 = randWord();
			end
			if (!issueValid && ($random(seed) & 1) != 0) begin
				issueValid = 1'b1;
				issueSrcA = regAddr'($random(seed));
				issueSrcB = regAddr'($random(seed));
			end
			opReady = ($random(seed) % 4) != 0;
			tick;
			if (lastWbFire[0]) begin
				wbValid0 = 1'b0;
				writes++;
			end
			if (lastWbFire[1]) begin
				wbValid1 = 1'b0;
				writes++;
			end
			if (lastIssueFire)
				issueValid = 1'b0;
		end
		wbValid0 = 1'b0;
		wbValid1 = 1'b0;
		issueValid = 1'b0;
		opReady = 1'b1;
		repeat (4) tick;
	endtask

	// ============================================================
	// run control
	// ============================================================

	// the tests take roughly 900 clk2x cycles and 4000 leaves ample margin
	initial begin
		while (cycleCount < 4000) begin
			@(posedge clk2x);
			cycleCount++;
		end
		$display("timeout, the tests did not finish within %0d clk2x cycles", cycleCount);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		wbValid0 = 1'b0;
		wbValid1 = 1'b0;
		wbAddr0 = '0;
		wbAddr1 = '0;
		wbData0 = '0;
		wbData1 = '0;
		issueValid = 1'b0;
		issueSrcA = '0;
		issueSrcB = '0;
		opReady = 1'b1;
		levelValid = 1'b0;
		level = '0;
		@(posedge rstN);
		// lane 0 owns the first edge after reset
		mPhase = 1'b1;
		mPend = 2'b00;
		mOpValid = 1'b0;
		mLevel = '0;
		resetState();
		laneWriteRead();
		sameRegister();
		stackPointer();
		backPressure();
		randomTraffic();
		$display("tests done, %0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
rtl/regPkg.sv
rtl/wbLaneIf.sv
rtl/wbCollector.sv
rtl/bankedRegfile.sv
rtl/operandStage.sv
rtl/pipeControl.sv
rtl/regfileTop.sv
bench/clockGen.sv
bench/regfileBench.sv

/* rtl/bankedRegfile.sv */
// 32x128 array with per-level stack pointer; curLevel must not change while a lane is pending
`timescale 1ns/1ps

module bankedRegfile (
	input logic clk2x,
	input regPkg::phaseT phase,
	input regPkg::levelSel curLevel,
	wbLaneIf.regfile lane0,
	wbLaneIf.regfile lane1,
	input regPkg::regAddr srcA,
	input regPkg::regAddr srcB,
	output regPkg::regWord rdA,
	output regPkg::regWord rdB
);
	import regPkg::*;

	// ============================================================
	// storage
	// ============================================================

	// the entry at spIndex in the main array is never used, the stack
	// pointer lives in its own small bank
	regWord mem [regCount];
	regWord sp [levelCount];

	// ============================================================
	// double-pumped write port
	// ============================================================

	// one physical write port is shared by the two lanes, the phase picks
	// the lane that owns this clk2x cycle
	logic wrEn;
	regAddr wrAddr;
	regWord wrData;

	always_comb begin
		if (phase) begin
			wrEn = lane0.commit;
			wrAddr = lane0.addr;
			wrData = lane0.data;
		end else begin
			wrEn = lane1.commit;
			wrAddr = lane1.addr;
			wrData = lane1.data;
		end
	end

	// a write to the stack pointer lands in the bank of the current level
	always_ff @(posedge clk2x) begin
		if (wrEn) begin
			if (wrAddr == regAddr'(spIndex))
				sp[curLevel] <= wrData;
			else
				mem[wrAddr] <= wrData;
		end
	end

	// ============================================================
	// read ports with bypass
	// ============================================================

	// local copies of the lane buffers keep the read function short
	logic pend0;
	logic pend1;
	regAddr addr0;
	regAddr addr1;
	regWord data0;
	regWord data1;

	assign pend0 = lane0.pending;
	assign pend1 = lane1.pending;
	assign addr0 = lane0.addr;
	assign addr1 = lane1.addr;
	assign data0 = lane0.data;
	assign data1 = lane1.data;

	// lane 1 writes later in the base cycle, so its value is the newer one
	// and it is checked first
	function automatic regWord readPort(input regAddr src);
		regWord stored;
		if (src == regAddr'(spIndex))
			stored = sp[curLevel];
		else
			stored = mem[src];
		if (src == '0)
			return '0;
		else if (pend1 && addr1 == src)
			return data1;
		else if (pend0 && addr0 == src)
			return data0;
		else
			return stored;
	endfunction

	assign rdA = readPort(srcA);
	assign rdB = readPort(srcB);

endmodule

/* rtl/operandStage.sv */
// single-entry operand buffer; the read pair is captured only on issueFire
`timescale 1ns/1ps

module operandStage (
	input logic clk2x,
	input logic rstN,
	input logic issueFire,
	input regPkg::regWord rdA,
	input regPkg::regWord rdB,
	input logic opReady,
	output logic opValid,
	output regPkg::regWord opA,
	output regPkg::regWord opB
);
	import regPkg::*;

	// ============================================================
	// occupancy
	// ============================================================

	// a new fire refills the stage even when the old pair leaves on the
	// same edge, so the stage can stream one pair per cycle
	always_ff @(posedge clk2x or negedge rstN) begin
		if (!rstN) begin
			opValid <= 1'b0;
		end else if (issueFire) begin
			opValid <= 1'b1;
		end else if (opReady) begin
			opValid <= 1'b0;
		end
	end

	// ============================================================
	// operand pair
	// ============================================================

	// control only fires when the stage is empty or draining, so the held
	// pair stays put while the consumer stalls
	regWord holdA;
	regWord holdB;

	always_ff @(posedge clk2x) begin
		if (issueFire) begin
			holdA <= rdA;
			holdB <= rdB;
		end
	end

	assign opA = holdA;
	assign opB = holdB;

endmodule

/* rtl/pipeControl.sv */
// phase, level and issue control; phase restarts high after reset so lane 0 owns the first slot
`timescale 1ns/1ps

module pipeControl (
	input logic clk2x,
	input logic rstN,
	wbLaneIf.control lane0,
	wbLaneIf.control lane1,
	input logic issueValid,
	output logic issueReady,
	output logic issueFire,
	input logic opValid,
	input logic opReady,
	input logic levelValid,
	input regPkg::levelSel level,
	output logic levelReady,
	output regPkg::levelSel curLevel,
	output regPkg::phaseT phase
);
	import regPkg::*;

	// ============================================================
	// base-cycle phase
	// ============================================================

	// two clk2x cycles form one base cycle, high is the lane 0 slot
	always_ff @(posedge clk2x or negedge rstN) begin
		if (!rstN)
			phase <= 1'b1;
		else
			phase <= ~phase;
	end

	// a slot only turns into a write when its lane has something buffered
	assign lane0.commit = phase & lane0.pending;
	assign lane1.commit = ~phase & lane1.pending;

	// ============================================================
	// operating level
	// ============================================================

	// a pending stack pointer write must land in the bank it was meant
	// for, so the level waits until both buffers have drained
	assign levelReady = ~lane0.pending & ~lane1.pending;

	always_ff @(posedge clk2x or negedge rstN) begin
		if (!rstN)
			curLevel <= '0;
		else if (levelValid && levelReady)
			curLevel <= level;
	end

	// ============================================================
	// issue acceptance
	// ============================================================

	// the operand stage has room when it is empty or is emptied on this edge
	assign issueReady = ~opValid | opReady;
	// the datapath captures its read pair when this is high
	assign issueFire = issueValid & issueReady;

endmodule

/* rtl/regPkg.sv */
// shared sizes and types of the register file; widths follow from the counts, keep counts powers of two
package regPkg;

	// ============================================================
	// sizes
	// ============================================================

	// one register word is a full 128-bit operand
	localparam int dataWidth = 128;
	// architectural registers, register 0 reads as zero
	localparam int regCount = 32;
	// operating levels, each one owns a private stack pointer
	localparam int levelCount = 4;
	// the register number that is banked per level
	localparam int spIndex = 31;

	// ============================================================
	// types
	// ============================================================

	// register number as it appears in issue and writeback traffic
	typedef logic [$clog2(regCount)-1:0] regAddr;
	// register value
	typedef logic [dataWidth-1:0] regWord;
	// current operating level
	typedef logic [$clog2(levelCount)-1:0] levelSel;
	// base-cycle phase, high is the lane 0 write slot and low the lane 1 slot
	typedef logic phaseT;

endpackage

/* rtl/regfileTop.sv */
// top of the operand-supply block; one issue slot with two sources, all handshakes valid/ready on clk2x
`timescale 1ns/1ps

module regfileTop (
	input logic clk2x,
	input logic rstN,
	// writeback lanes
	input logic wbValid0,
	input logic wbValid1,
	input regPkg::regAddr wbAddr0,
	input regPkg::regAddr wbAddr1,
	input regPkg::regWord wbData0,
	input regPkg::regWord wbData1,
	output logic wbReady0,
	output logic wbReady1,
	// issue channel
	input logic issueValid,
	input regPkg::regAddr issueSrcA,
	input regPkg::regAddr issueSrcB,
	output logic issueReady,
	// operand channel
	output logic opValid,
	input logic opReady,
	output regPkg::regWord opA,
	output regPkg::regWord opB,
	// level channel
	input logic levelValid,
	input regPkg::levelSel level,
	output logic levelReady
);
	import regPkg::*;

	// ============================================================
	// internal nets
	// ============================================================

	wbLaneIf lane0 ();
	wbLaneIf lane1 ();

	logic issueFire;
	phaseT phase;
	levelSel curLevel;
	regWord rdA;
	regWord rdB;

	// ============================================================
	// blocks
	// ============================================================

	// phase, level and the accept decisions
	pipeControl uControl (
		.clk2x(clk2x),
		.rstN(rstN),
		.lane0(lane0.control),
		.lane1(lane1.control),
		.issueValid(issueValid),
		.issueReady(issueReady),
		.issueFire(issueFire),
		.opValid(opValid),
		.opReady(opReady),
		.levelValid(levelValid),
		.level(level),
		.levelReady(levelReady),
		.curLevel(curLevel),
		.phase(phase)
	);

	// one buffered entry per writeback lane
	wbCollector uCollector (
		.clk2x(clk2x),
		.rstN(rstN),
		.wbValid0(wbValid0),
		.wbValid1(wbValid1),
		.wbAddr0(wbAddr0),
		.wbAddr1(wbAddr1),
		.wbData0(wbData0),
		.wbData1(wbData1),
		.wbReady0(wbReady0),
		.wbReady1(wbReady1),
		.lane0(lane0.collector),
		.lane1(lane1.collector)
	);

	// storage, banked stack pointer and bypass
	bankedRegfile uRegfile (
		.clk2x(clk2x),
		.phase(phase),
		.curLevel(curLevel),
		.lane0(lane0.regfile),
		.lane1(lane1.regfile),
		.srcA(issueSrcA),
		.srcB(issueSrcB),
		.rdA(rdA),
		.rdB(rdB)
	);

	// operand pair register toward the consumer
	operandStage uOperand (
		.clk2x(clk2x),
		.rstN(rstN),
		.issueFire(issueFire),
		.rdA(rdA),
		.rdB(rdB),
		.opReady(opReady),
		.opValid(opValid),
		.opA(opA),
		.opB(opB)
	);

endmodule

/* rtl/wbCollector.sv */
// holds one writeback per lane until its slot; a lane sustains at most one write per base cycle
`timescale 1ns/1ps

module wbCollector (
	input logic clk2x,
	input logic rstN,
	input logic wbValid0,
	input logic wbValid1,
	input regPkg::regAddr wbAddr0,
	input regPkg::regAddr wbAddr1,
	input regPkg::regWord wbData0,
	input regPkg::regWord wbData1,
	output logic wbReady0,
	output logic wbReady1,
	wbLaneIf.collector lane0,
	wbLaneIf.collector lane1
);
	import regPkg::*;

	// ============================================================
	// lane vectors
	// ============================================================

	// both lanes run the same buffer logic, so they are gathered into
	// small arrays and handled by one loop
	logic [1:0] inValid;
	logic [1:0] inReady;
	logic [1:0] commit;
	logic [1:0] pending;
	regAddr inAddr [2];
	regWord inData [2];
	regAddr heldAddr [2];
	regWord heldData [2];

	assign inValid = {wbValid1, wbValid0};
	assign inAddr[0] = wbAddr0;
	assign inAddr[1] = wbAddr1;
	assign inData[0] = wbData0;
	assign inData[1] = wbData1;
	assign commit = {lane1.commit, lane0.commit};

	// a buffer that empties on this edge can take the next result at once,
	// this is what lets a lane write on every base cycle
	assign inReady = ~pending | commit;
	assign wbReady0 = inReady[0];
	assign wbReady1 = inReady[1];

	// ============================================================
	// entry state
	// ============================================================

	// occupancy is control state and clears on reset
	always_ff @(posedge clk2x or negedge rstN) begin
		if (!rstN) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// a load wins over a commit on the same edge
				if (inValid[i] && inReady[i])
					pending[i] <= 1'b1;
				else if (commit[i])
					pending[i] <= 1'b0;
			end
		end
	end

	// the payload is only looked at while pending is set
	always_ff @(posedge clk2x) begin
		for (int i = 0; i < 2; i++) begin
			if (inValid[i] && inReady[i]) begin
				heldAddr[i] <= inAddr[i];
				heldData[i] <= inData[i];
			end
		end
	end

	// hand the entries to the lane interfaces
	assign lane0.pending = pending[0];
	assign lane0.addr = heldAddr[0];
	assign lane0.data = heldData[0];
	assign lane1.pending = pending[1];
	assign lane1.addr = heldAddr[1];
	assign lane1.data = heldData[1];

endmodule

/* rtl/wbLaneIf.sv */
// one buffered writeback lane; commit is only valid for a single clk2x edge and is never held
`timescale 1ns/1ps

interface wbLaneIf;
	import regPkg::*;

	// ============================================================
	// lane signals
	// ============================================================

	// the lane buffer holds an entry that is not yet in the array
	logic pending;
	// destination register of the held entry
	regAddr addr;
	// result value of the held entry
	regWord data;
	// the held entry is written on this edge
	logic commit;

	// ============================================================
	// views
	// ============================================================

	// the buffer owns the entry and learns when it has been written
	modport collector (
		output pending,
		output addr,
		output data,
		input commit
	);

	// control only needs occupancy to schedule the write slot
	modport control (
		input pending,
		output commit
	);

	// the array uses pending for bypass and commit for the write
	modport regfile (
		input pending,
		input addr,
		input data,
		input commit
	);

endinterface
